// ==== common/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

  localparam int OPW = 5;
  localparam int PCW = 32;
  localparam int HALFW = 16;
  localparam int CCRW = 4;
  localparam int STACKDEPTH = 16;
  localparam int SPW = 4;

  localparam logic [PCW-1:0] INTVECTOR = 32'h0000_0100;

  localparam logic [OPW-1:0] OPNOP = 5'b00000;
  localparam logic [OPW-1:0] OPMOV = 5'b00011;
  localparam logic [OPW-1:0] OPADD = 5'b00100;
  localparam logic [OPW-1:0] OPSUB = 5'b00101;
  localparam logic [OPW-1:0] OPSTD = 5'b00111;
  localparam logic [OPW-1:0] OPOUT = 5'b00110;
  localparam logic [OPW-1:0] OPIN = 5'b01111;
  localparam logic [OPW-1:0] OPLDD = 5'b10000;
  localparam logic [OPW-1:0] OPLDM = 5'b10001;
  localparam logic [OPW-1:0] OPPOP = 5'b10010;
  localparam logic [OPW-1:0] OPPUSH = 5'b10011;
  localparam logic [OPW-1:0] OPCALL = 5'b11000;
  localparam logic [OPW-1:0] OPRET = 5'b11001;
  localparam logic [OPW-1:0] OPRTI = 5'b11010;

  // mov, add, sub, the 01xxx group, ldd, ldm and pop write a register.
  localparam logic [31:0] REGWRSET = 32'h0007_FF38;

  // sequencer state codes.
  localparam int STW = 4;
  localparam logic [STW-1:0] STIDLE = 4'd0;
  localparam logic [STW-1:0] STCALLHIGH = 4'd1;
  localparam logic [STW-1:0] STCALLLOW = 4'd2;
  localparam logic [STW-1:0] STRETLOW = 4'd3;
  localparam logic [STW-1:0] STRETHIGH = 4'd4;
  localparam logic [STW-1:0] STINTHIGH = 4'd5;
  localparam logic [STW-1:0] STINTLOW = 4'd6;
  localparam logic [STW-1:0] STINTCCR = 4'd7;
  localparam logic [STW-1:0] STRTICCR = 4'd8;
  localparam logic [STW-1:0] STRTILOW = 4'd9;
  localparam logic [STW-1:0] STRTIHIGH = 4'd10;

  // push data select.
  localparam int DSW = 2;
  localparam logic [DSW-1:0] DSELPCHIGH = 2'd0;
  localparam logic [DSW-1:0] DSELPCLOW = 2'd1;
  localparam logic [DSW-1:0] DSELCCR = 2'd2;

endpackage

// ==== rtl/opDecoder.sv ====
`timescale 1ns/1ps

module opDecoder (
  input  logic [cpuCtrlPkg::OPW-1:0] opCode,
  output logic [cpuCtrlPkg::OPW-1:0] aluOp,
  output logic                       regWr,
  output logic                       memRd,
  output logic                       memWr,
  output logic                       aluSrc,
  output logic                       ldm,
  output logic                       memToReg,
  output logic                       portRd,
  output logic                       portWr,
  output logic                       isCall,
  output logic                       isRet,
  output logic                       isRti
);

  assign aluOp = opCode; // the ALU decodes its own function.

  assign regWr = cpuCtrlPkg::REGWRSET[opCode];

  // call, ret and rti go through the on-chip stack and not the data memory.
  assign memRd = (opCode == cpuCtrlPkg::OPLDD) ||
                 (opCode == cpuCtrlPkg::OPPOP);

  assign memWr = (opCode == cpuCtrlPkg::OPSTD) ||
                 (opCode == cpuCtrlPkg::OPPUSH);

  // second operand comes from the immediate or offset field.
  assign aluSrc = (opCode == cpuCtrlPkg::OPLDM) ||
                  (opCode == cpuCtrlPkg::OPLDD) ||
                  (opCode == cpuCtrlPkg::OPSTD);

  assign ldm = (opCode == cpuCtrlPkg::OPLDM);

  assign memToReg = (opCode == cpuCtrlPkg::OPLDD) ||
                    (opCode == cpuCtrlPkg::OPPOP);

  assign portRd = (opCode == cpuCtrlPkg::OPIN);
  assign portWr = (opCode == cpuCtrlPkg::OPOUT);

  assign isCall = (opCode == cpuCtrlPkg::OPCALL);
  assign isRet = (opCode == cpuCtrlPkg::OPRET);
  assign isRti = (opCode == cpuCtrlPkg::OPRTI);

endmodule

// ==== stackSeq/stackSequencer.sv ====
`timescale 1ns/1ps

module stackSequencer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       enable,
  input  logic                       interrupt,
  input  logic                       isCall,
  input  logic                       isRet,
  input  logic                       isRti,
  output logic                       busy,
  output logic                       push,
  output logic                       pop,
  output logic                       stackWr,
  output logic [cpuCtrlPkg::DSW-1:0] dataSel,
  output logic                       pcLoadTarget,
  output logic                       pcLoadVector,
  output logic                       pcRestoreHigh,
  output logic                       pcRestoreLow,
  output logic                       ccrRestore
);

  logic [cpuCtrlPkg::STW-1:0] state;
  logic [cpuCtrlPkg::STW-1:0] nextState;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= cpuCtrlPkg::STIDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = cpuCtrlPkg::STIDLE;
    case (state)
      cpuCtrlPkg::STIDLE: begin
        if (interrupt) begin
          nextState = cpuCtrlPkg::STINTHIGH; // interrupt wins over any opcode.
        end else if (enable && isCall) begin
          nextState = cpuCtrlPkg::STCALLHIGH;
        end else if (enable && isRet) begin
          nextState = cpuCtrlPkg::STRETLOW;
        end else if (enable && isRti) begin
          nextState = cpuCtrlPkg::STRTICCR;
        end
      end
      cpuCtrlPkg::STCALLHIGH: nextState = cpuCtrlPkg::STCALLLOW;
      cpuCtrlPkg::STRETLOW:   nextState = cpuCtrlPkg::STRETHIGH;
      cpuCtrlPkg::STINTHIGH:  nextState = cpuCtrlPkg::STINTLOW;
      cpuCtrlPkg::STINTLOW:   nextState = cpuCtrlPkg::STINTCCR;
      cpuCtrlPkg::STRTICCR:   nextState = cpuCtrlPkg::STRTILOW;
      cpuCtrlPkg::STRTILOW:   nextState = cpuCtrlPkg::STRTIHIGH;
      default:                nextState = cpuCtrlPkg::STIDLE;
    endcase
  end

  // strobes are decoded from the state and act on the edge that leaves it.
  always_comb begin
    push = 1'b0;
    pop = 1'b0;
    dataSel = cpuCtrlPkg::DSELPCHIGH;
    pcLoadTarget = 1'b0;
    pcLoadVector = 1'b0;
    pcRestoreHigh = 1'b0;
    pcRestoreLow = 1'b0;
    ccrRestore = 1'b0;
    case (state)
      cpuCtrlPkg::STCALLHIGH, cpuCtrlPkg::STINTHIGH: begin
        push = 1'b1;
      end
      cpuCtrlPkg::STCALLLOW: begin
        push = 1'b1;
        dataSel = cpuCtrlPkg::DSELPCLOW;
        pcLoadTarget = 1'b1;
      end
      cpuCtrlPkg::STINTLOW: begin
        push = 1'b1;
        dataSel = cpuCtrlPkg::DSELPCLOW;
      end
      cpuCtrlPkg::STINTCCR: begin
        push = 1'b1;
        dataSel = cpuCtrlPkg::DSELCCR;
        pcLoadVector = 1'b1;
      end
      cpuCtrlPkg::STRETLOW, cpuCtrlPkg::STRTILOW: begin
        pop = 1'b1;
        pcRestoreLow = 1'b1;
      end
      cpuCtrlPkg::STRETHIGH, cpuCtrlPkg::STRTIHIGH: begin
        pop = 1'b1;
        pcRestoreHigh = 1'b1;
      end
      cpuCtrlPkg::STRTICCR: begin
        pop = 1'b1;
        ccrRestore = 1'b1;
      end
      default: ;
    endcase
  end

  assign stackWr = push; // every push cycle stores one word.
  assign busy = (state != cpuCtrlPkg::STIDLE);

  assert property (@(posedge clk) disable iff (rst) !(push && pop))
    else $error("stack push and pop in the same cycle.");

  // every busy cycle moves the stack, and an idle cycle never does.
  assert property (@(posedge clk) disable iff (rst) busy == (push || pop))
    else $error("busy does not match the stack activity.");

endmodule

// ==== stackSeq/stackPointer.sv ====
`timescale 1ns/1ps

module stackPointer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       push,
  input  logic                       pop,
  output logic [cpuCtrlPkg::SPW-1:0] sp,
  output logic [cpuCtrlPkg::SPW-1:0] addr
);

  localparam logic [cpuCtrlPkg::SPW-1:0] SPTOP = cpuCtrlPkg::SPW'(cpuCtrlPkg::STACKDEPTH - 1);

  // sp points at the next free entry, the stack grows down.
  assign addr = pop ? sp + 1'b1 : sp;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sp <= SPTOP;
    end else if (push && (sp != '0)) begin
      sp <= sp - 1'b1; // holds at 0 rather than wrapping.
    end else if (pop && (sp != SPTOP)) begin
      sp <= sp + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (rst) push |-> (sp != '0))
    else $error("stack overflow.");

  assert property (@(posedge clk) disable iff (rst) pop |-> (sp != SPTOP))
    else $error("stack underflow.");

endmodule

// ==== stackSeq/stackRam.sv ====
`timescale 1ns/1ps

module stackRam (
  input  logic                         clk,
  input  logic                         wr,
  input  logic [cpuCtrlPkg::SPW-1:0]   addr,
  input  logic [cpuCtrlPkg::HALFW-1:0] wrData,
  output logic [cpuCtrlPkg::HALFW-1:0] rdData
);

  logic [cpuCtrlPkg::HALFW-1:0] mem [cpuCtrlPkg::STACKDEPTH];

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[addr] <= wrData;
    end
  end

  assign rdData = mem[addr]; // a pop sees its word in the same cycle.

endmodule

// ==== rtl/contextRegs.sv ====
`timescale 1ns/1ps

module contextRegs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         enable,
  input  logic                         busy,
  input  logic [cpuCtrlPkg::PCW-1:0]   target,
  input  logic [cpuCtrlPkg::CCRW-1:0]  ccrIn,
  input  logic                         ccrWr,
  input  logic                         pcLoadTarget,
  input  logic                         pcLoadVector,
  input  logic                         pcRestoreHigh,
  input  logic                         pcRestoreLow,
  input  logic                         ccrRestore,
  input  logic [cpuCtrlPkg::HALFW-1:0] rdData,
  input  logic [cpuCtrlPkg::DSW-1:0]   dataSel,
  output logic [cpuCtrlPkg::PCW-1:0]   pc,
  output logic [cpuCtrlPkg::CCRW-1:0]  ccr,
  output logic [cpuCtrlPkg::HALFW-1:0] pushData
);

  logic [cpuCtrlPkg::PCW-1:0]   targetLatch;
  logic [cpuCtrlPkg::HALFW-1:0] pcLowLatch;
  logic [cpuCtrlPkg::CCRW-1:0]  ccrLatch;
  logic                         ccrPend;

  // the last idle edge is the start edge, so the call target is frozen there.
  always_ff @(posedge clk) begin
    if (!busy) begin
      targetLatch <= target;
    end
    if (pcRestoreLow) begin
      pcLowLatch <= rdData;
    end
    if (ccrRestore) begin
      ccrLatch <= rdData[cpuCtrlPkg::CCRW-1:0];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
      ccr <= '0;
      ccrPend <= 1'b0;
    end else begin
      if (pcLoadTarget) begin
        pc <= targetLatch;
      end else if (pcLoadVector) begin
        pc <= cpuCtrlPkg::INTVECTOR;
      end else if (pcRestoreHigh) begin
        pc <= {rdData, pcLowLatch}; // whole pc changes in one edge.
      end else if (enable && !busy) begin
        pc <= pc + 1'b1;
      end

      // rti restores ccr together with pc, ret leaves it alone.
      if (pcRestoreHigh && ccrPend) begin
        ccr <= ccrLatch;
      end else if (ccrWr && !busy) begin
        ccr <= ccrIn;
      end

      if (ccrRestore) begin
        ccrPend <= 1'b1;
      end else if (pcRestoreHigh) begin
        ccrPend <= 1'b0;
      end
    end
  end

  always_comb begin
    case (dataSel)
      cpuCtrlPkg::DSELPCHIGH: pushData = pc[cpuCtrlPkg::PCW-1:cpuCtrlPkg::HALFW];
      cpuCtrlPkg::DSELPCLOW:  pushData = pc[cpuCtrlPkg::HALFW-1:0];
      cpuCtrlPkg::DSELCCR:    pushData = {{(cpuCtrlPkg::HALFW - cpuCtrlPkg::CCRW){1'b0}}, ccr};
      default:                pushData = '0;
    endcase
  end

endmodule

// ==== rtl/controlTop.sv ====
`timescale 1ns/1ps

module controlTop (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        enable,
  input  logic [cpuCtrlPkg::OPW-1:0]  opCode,
  input  logic [cpuCtrlPkg::PCW-1:0]  target,
  input  logic                        interrupt,
  input  logic [cpuCtrlPkg::CCRW-1:0] ccrIn,
  input  logic                        ccrWr,
  output logic [cpuCtrlPkg::OPW-1:0]  aluOp,
  output logic                        regWr,
  output logic                        memRd,
  output logic                        memWr,
  output logic                        aluSrc,
  output logic                        ldm,
  output logic                        memToReg,
  output logic                        portRd,
  output logic                        portWr,
  output logic [cpuCtrlPkg::PCW-1:0]  pc,
  output logic [cpuCtrlPkg::CCRW-1:0] ccr,
  output logic [cpuCtrlPkg::SPW-1:0]  sp,
  output logic                        busy
);

  logic [cpuCtrlPkg::OPW-1:0]   decAluOp;
  logic                         decRegWr;
  logic                         decMemRd;
  logic                         decMemWr;
  logic                         decAluSrc;
  logic                         decLdm;
  logic                         decMemToReg;
  logic                         decPortRd;
  logic                         decPortWr;
  logic                         isCall;
  logic                         isRet;
  logic                         isRti;
  logic                         issue;
  logic                         pcStep;
  logic                         push;
  logic                         pop;
  logic                         stackWr;
  logic [cpuCtrlPkg::DSW-1:0]   dataSel;
  logic                         pcLoadTarget;
  logic                         pcLoadVector;
  logic                         pcRestoreHigh;
  logic                         pcRestoreLow;
  logic                         ccrRestore;
  logic [cpuCtrlPkg::SPW-1:0]   stackAddr;
  logic [cpuCtrlPkg::HALFW-1:0] pushData;
  logic [cpuCtrlPkg::HALFW-1:0] rdData;

  opDecoder opDecoder_i (
    .opCode(opCode),
    .aluOp(decAluOp),
    .regWr(decRegWr),
    .memRd(decMemRd),
    .memWr(decMemWr),
    .aluSrc(decAluSrc),
    .ldm(decLdm),
    .memToReg(decMemToReg),
    .portRd(decPortRd),
    .portWr(decPortWr),
    .isCall(isCall),
    .isRet(isRet),
    .isRti(isRti)
  );

  assign issue = enable && !busy; // an opcode only counts while the sequencer is idle.

  assign aluOp = issue ? decAluOp : '0;
  assign regWr = issue && decRegWr;
  assign memRd = issue && decMemRd;
  assign memWr = issue && decMemWr;
  assign aluSrc = issue && decAluSrc;
  assign ldm = issue && decLdm;
  assign memToReg = issue && decMemToReg;
  assign portRd = issue && decPortRd;
  assign portWr = issue && decPortWr;

  // interrupt entry saves the pc of the instruction it cut off.
  assign pcStep = enable && !interrupt;

  stackSequencer stackSequencer_i (
    .clk(clk),
    .rst(rst),
    .enable(enable),
    .interrupt(interrupt),
    .isCall(isCall),
    .isRet(isRet),
    .isRti(isRti),
    .busy(busy),
    .push(push),
    .pop(pop),
    .stackWr(stackWr),
    .dataSel(dataSel),
    .pcLoadTarget(pcLoadTarget),
    .pcLoadVector(pcLoadVector),
    .pcRestoreHigh(pcRestoreHigh),
    .pcRestoreLow(pcRestoreLow),
    .ccrRestore(ccrRestore)
  );

  stackPointer stackPointer_i (
    .clk(clk),
    .rst(rst),
    .push(push),
    .pop(pop),
    .sp(sp),
    .addr(stackAddr)
  );

  stackRam stackRam_i (
    .clk(clk),
    .wr(stackWr),
    .addr(stackAddr),
    .wrData(pushData),
    .rdData(rdData)
  );

  contextRegs contextRegs_i (
    .clk(clk),
    .rst(rst),
    .enable(pcStep),
    .busy(busy),
    .target(target),
    .ccrIn(ccrIn),
    .ccrWr(ccrWr),
    .pcLoadTarget(pcLoadTarget),
    .pcLoadVector(pcLoadVector),
    .pcRestoreHigh(pcRestoreHigh),
    .pcRestoreLow(pcRestoreLow),
    .ccrRestore(ccrRestore),
    .rdData(rdData),
    .dataSel(dataSel),
    .pc(pc),
    .ccr(ccr),
    .pushData(pushData)
  );

endmodule

// ==== verification/controlTop_tb.sv ====
`timescale 1ns/1ps

module controlTop_tb;

  localparam int NROWS = 30;
  localparam int TIMEOUTLIMIT = NROWS * 6 + 50;

  logic                        clk;
  logic                        rst;
  logic                        enable;
  logic [cpuCtrlPkg::OPW-1:0]  opCode;
  logic [cpuCtrlPkg::PCW-1:0]  target;
  logic                        interrupt;
  logic [cpuCtrlPkg::CCRW-1:0] ccrIn;
  logic                        ccrWr;
  logic [cpuCtrlPkg::OPW-1:0]  aluOp;
  logic                        regWr;
  logic                        memRd;
  logic                        memWr;
  logic                        aluSrc;
  logic                        ldm;
  logic                        memToReg;
  logic                        portRd;
  logic                        portWr;
  logic [cpuCtrlPkg::PCW-1:0]  pc;
  logic [cpuCtrlPkg::CCRW-1:0] ccr;
  logic [cpuCtrlPkg::SPW-1:0]  sp;
  logic                        busy;

  // stimulus table, one entry per test.
  string                       rowName [NROWS];
  logic [cpuCtrlPkg::OPW-1:0]  rowOp [NROWS];
  logic                        rowEn [NROWS];
  logic                        rowIntr [NROWS];
  logic [cpuCtrlPkg::PCW-1:0]  rowTgt [NROWS];
  logic [cpuCtrlPkg::CCRW-1:0] rowCcrIn [NROWS];
  logic                        rowCcrWr [NROWS];
  logic                        rowNoise [NROWS];
  logic                        rowRand [NROWS];
  logic [7:0]                  rowFlags [NROWS]; // regWr memRd memWr aluSrc ldm memToReg portRd portWr.
  int                          rowCount = 0;

  // behavioral model of pc, ccr and the stack.
  logic [cpuCtrlPkg::PCW-1:0]   mPc;
  logic [cpuCtrlPkg::CCRW-1:0]  mCcr;
  logic [cpuCtrlPkg::SPW-1:0]   mSp;
  logic [cpuCtrlPkg::HALFW-1:0] mStack [cpuCtrlPkg::STACKDEPTH];

  int seed = 2;
  int errCount = 0;
  int checkCount = 0;
  int failedTests = 0;
  int cycleCount = 0;

  controlTop controlTop_i (
    .clk(clk), .rst(rst), .enable(enable), .opCode(opCode), .target(target),
    .interrupt(interrupt), .ccrIn(ccrIn), .ccrWr(ccrWr), .aluOp(aluOp),
    .regWr(regWr), .memRd(memRd), .memWr(memWr), .aluSrc(aluSrc), .ldm(ldm),
    .memToReg(memToReg), .portRd(portRd), .portWr(portWr), .pc(pc), .ccr(ccr),
    .sp(sp), .busy(busy)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic addRow(input string name, input logic [4:0] op, input logic en,
                        input logic intr, input logic [31:0] tgt, input logic [3:0] cin,
                        input logic cwr, input logic noisy, input logic randTgt,
                        input logic [7:0] flags);
    rowName[rowCount] = name;
    rowOp[rowCount] = op;
    rowEn[rowCount] = en;
    rowIntr[rowCount] = intr;
    rowTgt[rowCount] = tgt;
    rowCcrIn[rowCount] = cin;
    rowCcrWr[rowCount] = cwr;
    rowNoise[rowCount] = noisy;
    rowRand[rowCount] = randTgt;
    rowFlags[rowCount] = flags;
    rowCount++;
  endtask

  task automatic checkValue(input string testName, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("error: test %s, %s expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic driveQuiet();
    enable <= 1'b0;
    opCode <= cpuCtrlPkg::OPNOP;
    interrupt <= 1'b0;
    ccrWr <= 1'b0;
  endtask

  // inputs that the DUT must ignore while a sequence runs.
  task automatic driveNoise();
    logic [31:0] pick;
    pick = $random(seed);
    case (pick[1:0])
      2'd0:    opCode <= cpuCtrlPkg::OPCALL;
      2'd1:    opCode <= cpuCtrlPkg::OPRET;
      2'd2:    opCode <= cpuCtrlPkg::OPRTI;
      default: opCode <= cpuCtrlPkg::OPADD;
    endcase
    enable <= 1'b1;
    interrupt <= 1'b1;
    ccrWr <= 1'b1;
    ccrIn <= pick[7:4];
    target <= $random(seed);
  endtask

  task automatic pushWord(input logic [15:0] w);
    mStack[mSp] = w;
    mSp = mSp - 1'b1;
  endtask

  task automatic popWord(output logic [15:0] w);
    mSp = mSp + 1'b1;
    w = mStack[mSp];
  endtask

  // applies one row to the model and gives the number of busy cycles.
  task automatic runModel(input int r, input logic [31:0] tgt, output int seqLen);
    logic [15:0] lowHalf;
    logic [15:0] highHalf;
    logic [15:0] ccrWord;
    seqLen = 0;
    if (rowCcrWr[r]) mCcr = rowCcrIn[r];
    if (rowIntr[r]) begin
      pushWord(mPc[31:16]); // the interrupted pc is saved as it stands.
      pushWord(mPc[15:0]);
      pushWord({12'h000, mCcr});
      mPc = cpuCtrlPkg::INTVECTOR;
      seqLen = 3;
    end else if (rowEn[r]) begin
      mPc = mPc + 32'd1;
      if (rowOp[r] == cpuCtrlPkg::OPCALL) begin
        pushWord(mPc[31:16]);
        pushWord(mPc[15:0]);
        mPc = tgt;
        seqLen = 2;
      end else if (rowOp[r] == cpuCtrlPkg::OPRET) begin
        popWord(lowHalf);
        popWord(highHalf);
        mPc = {highHalf, lowHalf};
        seqLen = 2;
      end else if (rowOp[r] == cpuCtrlPkg::OPRTI) begin
        popWord(ccrWord);
        popWord(lowHalf);
        popWord(highHalf);
        mPc = {highHalf, lowHalf};
        mCcr = ccrWord[3:0];
        seqLen = 3;
      end
    end
  endtask

  initial begin
    while (cycleCount < TIMEOUTLIMIT) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUTLIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int r;
    int k;
    int seqLen;
    int errBefore;
    logic [31:0] tgt;
    logic [7:0] expFlags;
    logic [cpuCtrlPkg::OPW-1:0] expAluOp;

    addRow("nop", cpuCtrlPkg::OPNOP, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b0000_0000);
    addRow("mov", cpuCtrlPkg::OPMOV, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b1000_0000);
    addRow("add", cpuCtrlPkg::OPADD, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b1000_0000);
    addRow("sub", cpuCtrlPkg::OPSUB, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b1000_0000);
    addRow("std", cpuCtrlPkg::OPSTD, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b0011_0000);
    addRow("out", cpuCtrlPkg::OPOUT, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b0000_0001);
    addRow("in", cpuCtrlPkg::OPIN, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b1000_0010);
    addRow("ldd", cpuCtrlPkg::OPLDD, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b1101_0100);
    addRow("ldm", cpuCtrlPkg::OPLDM, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b1001_1000);
    addRow("pop", cpuCtrlPkg::OPPOP, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b1100_0100);
    addRow("push", cpuCtrlPkg::OPPUSH, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b0010_0000);
    addRow("ldd disabled", cpuCtrlPkg::OPLDD, 0, 0, 32'h0, 4'h0, 0, 0, 0, 8'b1101_0100);
    addRow("push disabled", cpuCtrlPkg::OPPUSH, 0, 0, 32'h0, 4'h0, 0, 0, 0, 8'b0010_0000);
    addRow("ccr write", cpuCtrlPkg::OPNOP, 1, 0, 32'h0, 4'hA, 1, 0, 0, 8'b0000_0000);
    addRow("ccr write disabled", cpuCtrlPkg::OPNOP, 0, 0, 32'h0, 4'h5, 1, 0, 0, 8'b0);
    addRow("call", cpuCtrlPkg::OPCALL, 1, 0, 32'h0001_2340, 4'h0, 0, 0, 0, 8'b0);
    addRow("ret", cpuCtrlPkg::OPRET, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b0);
    addRow("interrupt", cpuCtrlPkg::OPADD, 1, 1, 32'h0, 4'h0, 0, 0, 0, 8'b1000_0000);
    addRow("ccr write in isr", cpuCtrlPkg::OPNOP, 1, 0, 32'h0, 4'h3, 1, 0, 0, 8'b0);
    addRow("rti", cpuCtrlPkg::OPRTI, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b0);
    addRow("call busy noise", cpuCtrlPkg::OPCALL, 1, 0, 32'h00AB_CD00, 4'h0, 0, 1, 0, 8'b0);
    addRow("ret busy noise", cpuCtrlPkg::OPRET, 1, 0, 32'h0, 4'h0, 0, 1, 0, 8'b0);
    addRow("interrupt busy noise", cpuCtrlPkg::OPNOP, 0, 1, 32'h0, 4'h0, 0, 1, 0, 8'b0);
    addRow("rti busy noise", cpuCtrlPkg::OPRTI, 1, 0, 32'h0, 4'h0, 0, 1, 0, 8'b0);
    addRow("nested call 1", cpuCtrlPkg::OPCALL, 1, 0, 32'h0, 4'h0, 0, 0, 1, 8'b0);
    addRow("nested call 2", cpuCtrlPkg::OPCALL, 1, 0, 32'h0, 4'h0, 0, 0, 1, 8'b0);
    addRow("nested ret 2", cpuCtrlPkg::OPRET, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b0);
    addRow("nested ret 1", cpuCtrlPkg::OPRET, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b0);
    addRow("interrupt over call", cpuCtrlPkg::OPCALL, 1, 1, 32'h0000_4000, 4'h0, 0, 0, 0, 8'b0);
    addRow("rti after priority", cpuCtrlPkg::OPRTI, 1, 0, 32'h0, 4'h0, 0, 0, 0, 8'b0);

    rst <= 1'b1;
    target <= '0;
    ccrIn <= '0;
    driveQuiet();
    mPc = '0;
    mCcr = '0;
    mSp = 4'd15;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkValue("reset", "pc", 32'h0, pc);
    checkValue("reset", "sp", 32'd15, 32'(sp));
    checkValue("reset", "busy", 32'h0, 32'(busy));

    for (r = 0; r < NROWS; r++) begin
      errBefore = errCount;
      if (rowRand[r]) tgt = $random(seed);
      else tgt = rowTgt[r];
      @(posedge clk);
      opCode <= rowOp[r];
      enable <= rowEn[r];
      interrupt <= rowIntr[r];
      target <= tgt;
      ccrIn <= rowCcrIn[r];
      ccrWr <= rowCcrWr[r];
      @(negedge clk);
      expAluOp = rowEn[r] ? rowOp[r] : '0; // flags are gated off when not enabled.
      expFlags = rowEn[r] ? rowFlags[r] : 8'h00;
      checkValue(rowName[r], "aluOp", 32'(expAluOp), 32'(aluOp));
      checkValue(rowName[r], "flags", 32'(expFlags),
                 32'({regWr, memRd, memWr, aluSrc, ldm, memToReg, portRd, portWr}));
      runModel(r, tgt, seqLen);
      @(posedge clk); // start edge.
      if (rowNoise[r] && seqLen > 0) driveNoise();
      else driveQuiet();
      @(negedge clk);
      checkValue(rowName[r], "busy", 32'(seqLen > 0), 32'(busy));
      for (k = 1; k < seqLen; k++) begin
        @(posedge clk);
        if (rowNoise[r]) driveNoise();
      end
      if (seqLen > 0) begin
        @(posedge clk); // last sequence edge, the next idle edge must see quiet inputs.
        driveQuiet();
        @(negedge clk);
      end
      while (busy) @(negedge clk);
      checkValue(rowName[r], "pc", mPc, pc);
      checkValue(rowName[r], "ccr", 32'(mCcr), 32'(ccr));
      checkValue(rowName[r], "sp", 32'(mSp), 32'(sp));
      if (errCount == errBefore) begin
        $display("test %s: passed", rowName[r]);
      end else begin
        failedTests++;
        $display("test %s: failed", rowName[r]);
      end
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d", NROWS, failedTests,
             checkCount, errCount);
    if (errCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
common/cpuCtrlPkg.sv
rtl/opDecoder.sv
stackSeq/stackSequencer.sv
stackSeq/stackPointer.sv
stackSeq/stackRam.sv
rtl/contextRegs.sv
rtl/controlTop.sv
verification/controlTop_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the controlTop testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f files.f \
  --top-module controlTop_tb -o controlTop_sim

./obj_dir/controlTop_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "RESULT: PASS" sim.log
